/* encTrace.txt */
# kind echo status posLo posMid posHi csum position angle, all hex
# position and angle are the register values expected after the poll
good 02 00 45 23 01 65 00012345 91a2
good 02 00 ff ff 01 03 0001ffff ffff
bad  02 00 10 20 30 03 0001ffff ffff
none 00 00 00 00 00 00 0001ffff ffff
good 02 00 00 00 00 02 00000000 0000
good 02 81 34 12 7e db 007e1234 091a
bad  03 00 11 22 33 03 007e1234 091a
none 00 00 00 00 00 00 007e1234 091a
none 00 00 00 00 00 00 007e1234 091a
good 02 05 aa 55 0f f7 000f55aa aad5
bad  02 00 01 12 03 02 000f55aa aad5
good 02 00 fe ff ff fc 00fffffe ffff
good 02 00 01 00 00 03 00000001 0000
bad  02 40 80 00 00 82 00000001 0000
good 02 00 03 00 00 01 00000003 0001
none 00 00 00 00 00 00 00000003 0001
good 02 1f 78 56 34 07 00345678 2b3c
bad  02 00 aa bb cc de 00345678 2b3c
good 02 00 cd ab 00 64 0000abcd 55e6
good 02 00 00 00 80 82 00800000 0000

/* encInterface.f */
encPkg.sv
uartRx.sv
uartTx.sv
encPoller.sv
encApbRegs.sv
encInterface.sv
encInterfaceTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = encInterfaceTb
FILELIST  = encInterface.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

/* encInterfaceTb.sv */
`default_nettype none

module encInterfaceTb
    import encPkg::*;
();

    localparam int ClkPeriod    = 40;
    localparam int DriveDly     = 2;
    localparam int ClksPerBit   = 8;
    // reply window has to cover a six byte reply of 60 bit times
    localparam int ReplyTimeout = 800;
    localparam int PollGap      = 20;
    localparam logic [7:0] ReqByte = 8'h02;

    typedef struct packed {
        pollResultT  result;
        encFrameT    frame;
        logic [31:0] position;
        logic [15:0] angle;
    } traceLineT;

    logic      clk;
    logic      arstN;
    logic      rx;
    logic      tx;
    logic      txEnable;
    apbReqT    apbReq;
    apbRspT    apbRsp;
    traceLineT lines[$];
    bit        traceLoaded;

    encInterface #(
        .ClksPerBit  (ClksPerBit),
        .ReplyTimeout(ReplyTimeout),
        .PollGap     (PollGap)
    ) encInterface_i (
        .clk     (clk),
        .arstN   (arstN),
        .rx      (rx),
        .tx      (tx),
        .txEnable(txEnable),
        .apbReq  (apbReq),
        .apbRsp  (apbRsp)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    task automatic abortRun(input string line);
        $display("%s", line);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic checkSample(input encSampleT got, input encSampleT want, input string what);
        if (got !== want) begin
            abortRun($sformatf("CHECK FAILED at %0t: %s position %h angle %h, expected %h %h",
                               $time, what, got.position, got.angle, want.position,
                               want.angle));
        end
    endtask

    task automatic checkResult(input pollResultT got, input pollResultT want, input string what);
        if (got !== want) begin
            abortRun($sformatf("CHECK FAILED at %0t: %s is %s, expected %s",
                               $time, what, got.name(), want.name()));
        end
    endtask

    task automatic checkCount(input logic [31:0] got, input logic [31:0] want,
                              input string what);
        if (got !== want) begin
            abortRun($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                               $time, what, got, want));
        end
    endtask

    task automatic checkByte(input logic [7:0] got, input logic [7:0] want, input string what);
        if (got !== want) begin
            abortRun($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                               $time, what, got, want));
        end
    endtask

    // prdata is checked by the caller, only the handshake bits here
    task automatic checkApbRsp(input apbRspT got, input apbRspT want, input string what);
        if (got.pready !== want.pready || got.pslverr !== want.pslverr) begin
            abortRun($sformatf("CHECK FAILED at %0t: %s pready %b pslverr %b, expected %b %b",
                               $time, what, got.pready, got.pslverr, want.pready,
                               want.pslverr));
        end
    endtask

    function automatic pollResultT outcomeOf(input encFrameT f);
        logic [7:0] sum;
        sum = f.echo ^ f.status ^ f.posLo ^ f.posMid ^ f.posHi;
        if (f.echo == ReqByte && f.csum == sum) begin
            return resGood;
        end else begin
            return resCsumErr;
        end
    endfunction

    task automatic loadTrace();
        int          fd;
        int          n;
        int          lineNo;
        string       text;
        logic [31:0] kindTag;
        logic [7:0]  bytes [6];
        logic [31:0] pos;
        logic [15:0] ang;
        logic [31:0] rulePos;
        logic [31:0] heldPos;
        logic [15:0] heldAng;
        pollResultT  declared;
        traceLineT   entry;
        heldPos = '0;
        heldAng = '0;
        lineNo  = 0;
        fd = $fopen("encTrace.txt", "r");
        if (fd == 0) begin
            abortRun("cannot open encTrace.txt for reading");
        end
        while (!$feof(fd)) begin
            text = "";
            void'($fgets(text, fd));
            lineNo++;
            if (text.len() > 0 && text[0] == "#") begin
                continue;
            end
            n = $sscanf(text, "%s %h %h %h %h %h %h %h %h", kindTag, bytes[0], bytes[1],
                        bytes[2], bytes[3], bytes[4], bytes[5], pos, ang);
            if (n <= 0) begin
                continue;
            end
            if (n != 9) begin
                abortRun($sformatf("trace line %0d has missing columns", lineNo));
            end
            entry.frame = {bytes[0], bytes[1], bytes[2], bytes[3], bytes[4], bytes[5]};
            entry.result = (kindTag == "none") ? resTimeout : outcomeOf(entry.frame);
            declared = (kindTag == "good") ? resGood :
                       (kindTag == {8'h00, "bad"}) ? resCsumErr :
                       (kindTag == "none") ? resTimeout : resNone;
            if (declared != entry.result) begin
                abortRun($sformatf("trace line %0d: kind does not agree with its bytes", lineNo));
            end
            // a good reply gives the new sample, anything else keeps the old one
            if (entry.result == resGood) begin
                rulePos = {8'h00, entry.frame.posHi, entry.frame.posMid, entry.frame.posLo};
                heldPos = rulePos;
                heldAng = rulePos[16:1];
            end
            if (pos != heldPos || ang != heldAng) begin
                abortRun($sformatf("trace line %0d: position or angle is inconsistent", lineNo));
            end
            entry.position = pos;
            entry.angle    = ang;
            lines.push_back(entry);
        end
        $fclose(fd);
        if (lines.size() == 0) begin
            abortRun("encTrace.txt holds no poll lines");
        end
        traceLoaded = 1'b1;
    endtask

    task automatic apbXfer(input logic write, input logic [4:0] addr, input logic [31:0] wdata,
                           output apbRspT rsp);
        @(posedge clk);
        #DriveDly;
        apbReq = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge clk);
        #DriveDly;
        apbReq.penable = 1'b1;
        // access phase, response settles before the completing edge
        @(negedge clk);
        rsp = apbRsp;
        @(posedge clk);
        #DriveDly;
        apbReq = '0;
    endtask

    task automatic apbRead(input logic [4:0] addr, output logic [31:0] data, input logic expErr);
        apbRspT rsp;
        apbXfer(1'b0, addr, 32'd0, rsp);
        checkApbRsp(rsp, '{prdata: 32'd0, pready: 1'b1, pslverr: expErr},
                    $sformatf("read of offset %h", addr));
        data = rsp.prdata;
    endtask

    task automatic apbWrite(input logic [4:0] addr, input logic [31:0] data, input logic expErr);
        apbRspT rsp;
        apbXfer(1'b1, addr, data, rsp);
        checkApbRsp(rsp, '{prdata: 32'd0, pready: 1'b1, pslverr: expErr},
                    $sformatf("write to offset %h", addr));
    endtask

    task automatic waitForResult(input pollResultT res, input logic [31:0] csumCnt,
                                 input logic [31:0] tmoCnt, output logic [31:0] d);
        d = '0;
        case (res)
            resGood: begin
                while (d[0] !== 1'b1) begin
                    apbRead(regStatus, d, 1'b0);
                end
            end
            resCsumErr: begin
                while (d !== csumCnt) begin
                    apbRead(regCsumErrs, d, 1'b0);
                end
            end
            default: begin
                while (d !== tmoCnt) begin
                    apbRead(regTimeouts, d, 1'b0);
                end
            end
        endcase
    endtask

    // sampled mid-bit on falling clock edges
    task automatic receiveRequest(output logic [7:0] b);
        @(negedge tx);
        repeat (ClksPerBit / 2) @(negedge clk);
        if (tx !== 1'b0 || txEnable !== 1'b1) begin
            abortRun("request start bit was not seen with txEnable high");
        end
        for (int k = 0; k < 8; k++) begin
            repeat (ClksPerBit) @(negedge clk);
            if (txEnable !== 1'b1) begin
                abortRun("txEnable dropped in the middle of the request");
            end
            b[k] = tx;
        end
        repeat (ClksPerBit) @(negedge clk);
        if (tx !== 1'b1) begin
            abortRun("request stop bit was not high");
        end
    endtask

    task automatic sendByte(input logic [7:0] b);
        logic [9:0] bits;
        bits = {1'b1, b, 1'b0};
        for (int k = 0; k < 10; k++) begin
            rx = bits[k];
            repeat (ClksPerBit) @(posedge clk);
            #DriveDly;
        end
    endtask

    // encoder side of the line, one trace line per request
    initial begin : encoderModel
        logic [7:0] reqByte;
        int         pollIdx;
        pollIdx = 0;
        forever begin
            wait (txEnable === 1'b1);
            receiveRequest(reqByte);
            checkByte(reqByte, ReqByte, "request byte on tx");
            wait (txEnable === 1'b0);
            if (pollIdx < lines.size() && lines[pollIdx].result != resTimeout) begin
                @(posedge clk);
                #DriveDly;
                for (int k = 0; k < 6; k++) begin
                    sendByte(lines[pollIdx].frame[47 - 8 * k -: 8]);
                end
            end
            pollIdx++;
        end
    end

    initial begin : watchdog
        longint limit;
        wait (traceLoaded);
        limit = longint'(lines.size()) * (11 * 10 * ClksPerBit + ReplyTimeout + PollGap) *
                ClkPeriod * 2;
        #(limit);
        abortRun("watchdog expired, the run hung before the trace was finished");
    end

    initial begin : mainSeq
        logic [31:0] d;
        logic [31:0] pos;
        logic [31:0] ang;
        logic [31:0] csumCnt;
        logic [31:0] tmoCnt;
        pollResultT  res;
        apbRspT      rsp;
        encSampleT   got;
        encSampleT   want;
        arstN   = 1'b0;
        rx      = 1'b1;
        apbReq  = '0;
        csumCnt = '0;
        tmoCnt  = '0;
        loadTrace();
        repeat (8) @(posedge clk);
        #DriveDly;
        arstN = 1'b1;

        // polling is off, the line has to stay released
        repeat (100) begin
            @(negedge clk);
            if (txEnable !== 1'b0 || tx !== 1'b1) begin
                abortRun("tx or txEnable moved while polling was disabled");
            end
        end
        for (int a = 0; a < 24; a += 4) begin
            apbRead(5'(a), d, 1'b0);
            checkCount(d, 32'd0, $sformatf("reset value at offset %h", a));
        end

        apbWrite(regPosition, 32'hdead_beef, 1'b1);
        apbXfer(1'b0, 5'h18, 32'd0, rsp);
        checkApbRsp(rsp, '{prdata: 32'd0, pready: 1'b1, pslverr: 1'b1}, "read of offset 18");
        apbRead(regPosition, d, 1'b0);
        checkCount(d, 32'd0, "regPosition after a rejected write");
        apbWrite(regCtrl, 32'd1, 1'b0);
        apbRead(regCtrl, d, 1'b0);
        checkCount(d, 32'd1, "regCtrl enable bit");

        foreach (lines[i]) begin
            res = lines[i].result;
            if (res == resCsumErr) begin
                csumCnt++;
            end
            if (res == resTimeout) begin
                tmoCnt++;
            end
            waitForResult(res, csumCnt, tmoCnt, d);
            if (res == resGood) begin
                checkCount(d, {29'd0, resGood, 1'b1}, "regStatus with a new sample");
            end
            // sampleReady is gone after the read above
            apbRead(regStatus, d, 1'b0);
            checkResult(pollResultT'(d[2:1]), res, "last result in regStatus");
            checkCount(d, {29'd0, res, 1'b0}, "regStatus after a clearing read");
            apbRead(regCsumErrs, d, 1'b0);
            checkCount(d, csumCnt, "regCsumErrs");
            apbRead(regTimeouts, d, 1'b0);
            checkCount(d, tmoCnt, "regTimeouts");
            apbRead(regPosition, pos, 1'b0);
            apbRead(regAngle, ang, 1'b0);
            checkCount({ang[31:16], 16'd0}, 32'd0, "upper half of regAngle");
            got  = '{position: pos, angle: ang[15:0], status: 8'h00, pad: 8'h00};
            want = '{position: lines[i].position, angle: lines[i].angle,
                     status: 8'h00, pad: 8'h00};
            checkSample(got, want, $sformatf("sample after trace line %0d", i + 1));
        end

        apbWrite(regCtrl, 32'd0, 1'b0);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* encInterface.sv */
`default_nettype none

module encInterface
    import encPkg::*;
#(
    parameter int ClksPerBit   = 13,
    parameter int ReplyTimeout = 32400,
    parameter int PollGap      = 324
) (
    input  logic   clk,
    input  logic   arstN,
    input  logic   rx,
    output logic   tx,
    output logic   txEnable,
    input  apbReqT apbReq,
    output apbRspT apbRsp
);

    logic [7:0] txData;
    logic       txStart;
    logic       txBusy;
    logic [7:0] rxData;
    logic       rxValid;
    logic       pollEnable;
    encSampleT  sample;
    pollResultT result;
    logic       resultValid;

    uartRx #(
        .ClksPerBit(ClksPerBit)
    ) uartRx_i (
        .clk    (clk),
        .arstN  (arstN),
        .rx     (rx),
        .rxData (rxData),
        .rxValid(rxValid)
    );

    uartTx #(
        .ClksPerBit(ClksPerBit)
    ) uartTx_i (
        .clk    (clk),
        .arstN  (arstN),
        .txData (txData),
        .txStart(txStart),
        .tx     (tx),
        .txBusy (txBusy)
    );

    encPoller #(
        .ReplyTimeout(ReplyTimeout),
        .PollGap     (PollGap)
    ) encPoller_i (
        .clk        (clk),
        .arstN      (arstN),
        .pollEnable (pollEnable),
        .txBusy     (txBusy),
        .rxData     (rxData),
        .rxValid    (rxValid),
        .txEnable   (txEnable),
        .txData     (txData),
        .txStart    (txStart),
        .sample     (sample),
        .result     (result),
        .resultValid(resultValid)
    );

    encApbRegs encApbRegs_i (
        .clk        (clk),
        .arstN      (arstN),
        .apbReq     (apbReq),
        .sample     (sample),
        .result     (result),
        .resultValid(resultValid),
        .apbRsp     (apbRsp),
        .pollEnable (pollEnable)
    );

endmodule

`default_nettype wire

/* encApbRegs.sv */
`default_nettype none

module encApbRegs
    import encPkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    input  apbReqT     apbReq,
    input  encSampleT  sample,
    input  pollResultT result,
    input  logic       resultValid,
    output apbRspT     apbRsp,
    output logic       pollEnable
);

    encSampleT   sampleReg;
    pollResultT  lastResult;
    logic        sampleReady;
    logic [31:0] csumErrs;
    logic [31:0] timeouts;
    logic [31:0] rdData;
    logic        addrHit;
    logic        access;
    logic        wrCtrl;
    logic        rdStatus;

    assign access   = apbReq.psel && apbReq.penable;
    assign wrCtrl   = access && apbReq.pwrite && (apbReq.paddr == regCtrl);
    assign rdStatus = access && !apbReq.pwrite && (apbReq.paddr == regStatus);

    always_comb begin
        addrHit = 1'b1;
        rdData  = '0;
        case (regAddrT'(apbReq.paddr))
            regCtrl:     rdData = {31'd0, pollEnable};
            regStatus:   rdData = {29'd0, lastResult, sampleReady};
            regPosition: rdData = sampleReg.position;
            regAngle:    rdData = {16'd0, sampleReg.angle};
            regCsumErrs: rdData = csumErrs;
            regTimeouts: rdData = timeouts;
            default:     addrHit = 1'b0;
        endcase
    end

    // zero wait states, only regCtrl is writable
    assign apbRsp.prdata  = rdData;
    assign apbRsp.pready  = 1'b1;
    assign apbRsp.pslverr = access &&
                            (!addrHit || (apbReq.pwrite && apbReq.paddr != regCtrl));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pollEnable  <= 1'b0;
            sampleReady <= 1'b0;
            lastResult  <= resNone;
            sampleReg   <= '0;
            csumErrs    <= '0;
            timeouts    <= '0;
        end else begin
            if (wrCtrl) begin
                pollEnable <= apbReq.pwdata[0];
            end
            if (rdStatus) begin
                sampleReady <= 1'b0;
            end
            if (resultValid) begin
                lastResult <= result;
                // a new sample beats a clearing read in the same cycle
                if (result == resGood) begin
                    sampleReady <= 1'b1;
                    sampleReg   <= sample;
                end
                if (result == resCsumErr && csumErrs != '1) begin
                    csumErrs <= csumErrs + 32'd1;
                end
                if (result == resTimeout && timeouts != '1) begin
                    timeouts <= timeouts + 32'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* encPoller.sv */
`default_nettype none

module encPoller
    import encPkg::*;
#(
    parameter int ReplyTimeout = 32400,
    parameter int PollGap      = 324
) (
    input  logic       clk,
    input  logic       arstN,
    input  logic       pollEnable,
    input  logic       txBusy,
    input  logic [7:0] rxData,
    input  logic       rxValid,
    output logic       txEnable,
    output logic [7:0] txData,
    output logic       txStart,
    output encSampleT  sample,
    output pollResultT result,
    output logic       resultValid
);

    localparam int MaxWait = (ReplyTimeout > PollGap) ? ReplyTimeout : PollGap;
    localparam int TimerW  = $clog2(MaxWait + 1);
    localparam logic [TimerW-1:0] ReplyLast = TimerW'(ReplyTimeout - 1);
    localparam logic [TimerW-1:0] GapLast   = TimerW'(PollGap - 1);

    pollStateT         state;
    logic [TimerW-1:0] timer;
    logic [2:0]        byteCnt;
    encFrameT          frame;
    encFrameT          nextFrame;
    logic              frameDone;
    logic              frameGood;
    logic [7:0]        csumCalc;
    logic [31:0]       position;

    assign txData = reqDataCode;

    // transceiver drives the line until the stop bit has left uartTx;
    // txStart covers the cycle before busy rises
    assign txEnable = (state == stSend) ||
                      ((state == stTxWait) && (txBusy || txStart));

    // frame as it stands once the current byte is shifted in
    assign nextFrame = {frame[39:0], rxData};
    assign frameDone = (state == stListen) && rxValid && (byteCnt == 3'd5);

    assign csumCalc = nextFrame.echo ^ nextFrame.status ^ nextFrame.posLo ^
                      nextFrame.posMid ^ nextFrame.posHi;
    assign frameGood = (nextFrame.echo == reqDataCode) && (nextFrame.csum == csumCalc);
    assign position  = {8'h00, nextFrame.posHi, nextFrame.posMid, nextFrame.posLo};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state       <= stIdle;
            timer       <= '0;
            byteCnt     <= '0;
            txStart     <= 1'b0;
            result      <= resNone;
            resultValid <= 1'b0;
        end else begin
            txStart     <= 1'b0;
            resultValid <= 1'b0;
            case (state)
                stIdle: begin
                    if (pollEnable) begin
                        state <= stSend;
                    end
                end
                stSend: begin
                    if (!txBusy) begin
                        txStart <= 1'b1;
                        state   <= stTxWait;
                    end
                end
                stTxWait: begin
                    // reply window opens as the request ends
                    if (!txBusy && !txStart) begin
                        state   <= stListen;
                        timer   <= '0;
                        byteCnt <= '0;
                    end
                end
                stListen: begin
                    if (frameDone) begin
                        resultValid <= 1'b1;
                        result      <= frameGood ? resGood : resCsumErr;
                        state       <= stGap;
                        timer       <= '0;
                    end else if (timer == ReplyLast) begin
                        resultValid <= 1'b1;
                        result      <= resTimeout;
                        state       <= stGap;
                        timer       <= '0;
                    end else begin
                        timer <= timer + 1'b1;
                        if (rxValid) begin
                            byteCnt <= byteCnt + 3'd1;
                        end
                    end
                end
                stGap: begin
                    // late bytes fall through here unseen
                    if (timer == GapLast) begin
                        state <= stIdle;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == stListen && rxValid) begin
            frame <= nextFrame;
        end
        // angle keeps the top 16 of the 17 single-turn bits
        if (frameDone && frameGood) begin
            sample <= '{position: position,
                        angle:    position[16:1],
                        status:   nextFrame.status,
                        pad:      8'h00};
        end
    end

endmodule

`default_nettype wire

/* uartTx.sv */
`default_nettype none

module uartTx #(
    parameter int ClksPerBit = 13
) (
    input  logic       clk,
    input  logic       arstN,
    input  logic [7:0] txData,
    input  logic       txStart,
    output logic       tx,
    output logic       txBusy
);

    typedef enum logic [1:0] {
        txIdle,
        txStartBit,
        txBits,
        txStopBit
    } txStateT;

    localparam int CntW = $clog2(ClksPerBit) + 1;
    localparam logic [CntW-1:0] FullBit = CntW'(ClksPerBit - 1);

    txStateT         state;
    logic [CntW-1:0] timer;
    logic [2:0]      bitIdx;
    logic [7:0]      dataReg;
    logic            bitEnd;

    assign bitEnd = (timer == FullBit);
    assign txBusy = (state != txIdle);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state  <= txIdle;
            timer  <= '0;
            bitIdx <= '0;
            tx     <= 1'b1;
        end else begin
            // timer restarts at each bit boundary and rests in idle
            if (state == txIdle || bitEnd) begin
                timer <= '0;
            end else begin
                timer <= timer + 1'b1;
            end
            case (state)
                txIdle: begin
                    if (txStart) begin
                        state <= txStartBit;
                        tx    <= 1'b0;
                    end
                end
                txStartBit: begin
                    if (bitEnd) begin
                        state  <= txBits;
                        bitIdx <= '0;
                        tx     <= dataReg[0];
                    end
                end
                txBits: begin
                    if (bitEnd) begin
                        if (bitIdx == 3'd7) begin
                            state <= txStopBit;
                            tx    <= 1'b1;
                        end else begin
                            bitIdx <= bitIdx + 3'd1;
                            tx     <= dataReg[bitIdx + 3'd1];
                        end
                    end
                end
                txStopBit: begin
                    if (bitEnd) begin
                        state <= txIdle;
                    end
                end
                default: state <= txIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == txIdle && txStart) begin
            dataReg <= txData;
        end
    end

endmodule

`default_nettype wire

/* uartRx.sv */
`default_nettype none

module uartRx #(
    parameter int ClksPerBit = 13
) (
    input  logic       clk,
    input  logic       arstN,
    input  logic       rx,
    output logic [7:0] rxData,
    output logic       rxValid
);

    typedef enum logic [1:0] {
        rxIdle,
        rxStart,
        rxBits,
        rxStop
    } rxStateT;

    localparam int CntW = $clog2(ClksPerBit) + 1;
    localparam logic [CntW-1:0] HalfBit = CntW'(ClksPerBit / 2);
    localparam logic [CntW-1:0] FullBit = CntW'(ClksPerBit - 1);

    rxStateT         state;
    logic [1:0]      rxSync;
    logic            rxPrev;
    logic [CntW-1:0] timer;
    logic [2:0]      bitIdx;
    logic            bitTick;

    // line idles high, so the synchronizer comes out of reset at 1
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rxSync <= 2'b11;
            rxPrev <= 1'b1;
        end else begin
            rxSync <= {rxSync[0], rx};
            rxPrev <= rxSync[1];
        end
    end

    assign bitTick = (state == rxBits) && (timer == FullBit);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state   <= rxIdle;
            timer   <= '0;
            bitIdx  <= '0;
            rxValid <= 1'b0;
        end else begin
            rxValid <= 1'b0;
            case (state)
                rxIdle: begin
                    timer <= '0;
                    // falling edge marks a start bit
                    if (rxPrev && !rxSync[1]) begin
                        state <= rxStart;
                    end
                end
                rxStart: begin
                    if (timer == HalfBit) begin
                        timer  <= '0;
                        bitIdx <= '0;
                        // glitch shorter than half a bit goes back to idle
                        state  <= rxSync[1] ? rxIdle : rxBits;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                rxBits: begin
                    if (bitTick) begin
                        timer  <= '0;
                        bitIdx <= bitIdx + 3'd1;
                        if (bitIdx == 3'd7) begin
                            state <= rxStop;
                        end
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                rxStop: begin
                    if (timer == FullBit) begin
                        state <= rxIdle;
                        // framing error drops the byte
                        rxValid <= rxSync[1];
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                default: state <= rxIdle;
            endcase
        end
    end

    // lsb first, so new bits enter at the top
    always_ff @(posedge clk) begin
        if (bitTick) begin
            rxData <= {rxSync[1], rxData[7:1]};
        end
    end

endmodule

`default_nettype wire

/* encPkg.sv */
`default_nettype none

package encPkg;

    // data request, the encoder echoes it as reply byte 0
    localparam logic [7:0] reqDataCode = 8'h02;

    // reply bytes in reception order, echo lands in the top byte
    typedef struct packed {
        logic [7:0] echo;
        logic [7:0] status;
        logic [7:0] posLo;
        logic [7:0] posMid;
        logic [7:0] posHi;
        logic [7:0] csum;
    } encFrameT;

    typedef struct packed {
        logic [31:0] position;
        logic [15:0] angle;
        logic [7:0]  status;
        logic [7:0]  pad;
    } encSampleT;

    typedef enum logic [1:0] {
        resNone,
        resGood,
        resCsumErr,
        resTimeout
    } pollResultT;

    typedef enum logic [2:0] {
        stIdle,
        stSend,
        stTxWait,
        stListen,
        stGap
    } pollStateT;

    // byte offsets on the APB port
    typedef enum logic [4:0] {
        regCtrl     = 5'h00,
        regStatus   = 5'h04,
        regPosition = 5'h08,
        regAngle    = 5'h0C,
        regCsumErrs = 5'h10,
        regTimeouts = 5'h14
    } regAddrT;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [4:0]  paddr;
        logic [31:0] pwdata;
    } apbReqT;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apbRspT;

endpackage

`default_nettype wire
